//--- sram_bank_top.f
+incdir+source
source/sram_bank_pkg.sv
source/region_deny_ctrl.sv
source/ahb_sram_slave.sv
source/endian_lane_steer.sv
source/sram_byte_array.sv
source/sram_bank_top.sv
verification/sram_bank_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the SRAM bank testbench with Verilator and runs it
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  -f sram_bank_top.f \
  --top-module sram_bank_tb \
  -o sim_sram_bank
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

output=$(./obj_dir/sim_sram_bank)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "test passed"; then
  exit 0
fi
exit 1

//--- verification/sram_bank_tb.sv
//==========================================================
// self-checking testbench for the AHB-Lite SRAM bank
// LFSR driven transfers checked against a byte level model
//==========================================================
`default_nettype none

`include "sram_bank_defs.svh"

module sram_bank_tb
  import sram_bank_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD_NS = 8;
  localparam int N_INIT        = 64;
  localparam int N_SEG         = 240;
  localparam int N_TOTAL       = N_INIT + 2 * N_SEG + 8;
  // a transfer never takes more than three cycles
  localparam int WATCHDOG_NS   = (N_TOTAL * 4 + 64) * CLK_PERIOD_NS;

  logic                         i_sys_hclk;
  logic                         i_sys_rst_b;
  ahb_req_t                     i_ahb_req;
  logic [`SRAM_BANK_DATA_W-1:0] i_hwdata;
  logic                         i_rd_deny;
  logic                         i_wr_deny;
  logic                         i_big_endian_b;
  logic [`SRAM_BANK_DATA_W-1:0] o_hrdata;
  logic                         o_hready;
  hresp_e                       o_hresp;
  logic                         o_idle;

  logic [15:0]                  lfsr_state;
  logic [15:0]                  win_base;
  logic [`SRAM_BANK_DATA_W-1:0] prev_wdata;
  logic [7:0]                   ref_mem [65536];
  // data phase tracked by the model
  logic                         dp_valid;
  logic                         dp_write;
  logic                         dp_deny;
  logic                         dp_raw;
  hsize_e                       dp_size;
  logic [15:0]                  dp_addr;
  int                           dp_cyc;
  int                           checks = 0;
  int                           errors = 0;

  sram_bank_top i_dut (
    .i_sys_hclk     (i_sys_hclk),
    .i_sys_rst_b    (i_sys_rst_b),
    .i_ahb_req      (i_ahb_req),
    .i_hwdata       (i_hwdata),
    .i_rd_deny      (i_rd_deny),
    .i_wr_deny      (i_wr_deny),
    .i_big_endian_b (i_big_endian_b),
    .o_hrdata       (o_hrdata),
    .o_hready       (o_hready),
    .o_hresp        (o_hresp),
    .o_idle         (o_idle)
  );

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // one LFSR step per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  // bus lane that carries memory byte m
  function automatic int bus_lane(input int m, input hsize_e size, input logic big_endian_b);
    if (big_endian_b || size == WORD)
      return m;
    else if (size == BYTE)
      return 3 - m;
    return m ^ 2;
  endfunction

  // little endian returns the whole word, big endian only the addressed lanes
  function automatic logic [`SRAM_BANK_DATA_W-1:0] expected_rdata(
    input logic [15:0] addr,
    input hsize_e      size,
    input logic        big_endian_b
  );
    logic [`SRAM_BANK_DATA_W-1:0] res;
    logic [15:0]                  base;
    int                           first;
    int                           nbytes;
    res    = '0;
    base   = {addr[15:2], 2'b00};
    first  = big_endian_b ? 0 : int'(addr[1:0]);
    nbytes = big_endian_b ? 4 : (1 << int'(size));
    for (int m = first; m < first + nbytes; m++)
    begin
      res[8 * bus_lane(m, size, big_endian_b) +: 8] = ref_mem[base + 16'(m)];
    end
    return res;
  endfunction

  task automatic commit_write(
    input logic [15:0]                  addr,
    input hsize_e                       size,
    input logic [`SRAM_BANK_DATA_W-1:0] wdata,
    input logic                         big_endian_b
  );
    logic [15:0] base;
    int          first;
    int          lane;
    base  = {addr[15:2], 2'b00};
    first = int'(addr[1:0]);
    for (int m = first; m < first + (1 << int'(size)); m++)
    begin
      lane = bus_lane(m, size, big_endian_b);
      ref_mem[base + 16'(m)] = wdata[8 * lane +: 8];
    end
  endtask

  task automatic flag_error(input string msg);
    errors++;
    $display("FAIL %0d ns: %s", $time, msg);
  endtask

  // drives one address phase plus the data of the previous one
  task automatic issue(
    input ahb_req_t                     req,
    input logic [`SRAM_BANK_DATA_W-1:0] wdata,
    input logic                         rd_deny,
    input logic                         wr_deny
  );
    logic accepted;
    i_ahb_req  <= req;
    i_hwdata   <= prev_wdata;
    i_rd_deny  <= rd_deny;
    i_wr_deny  <= wr_deny;
    prev_wdata = wdata;
    accepted   = 1'b0;
    // held while the bank stretches the cycle
    while (!accepted)
    begin
      @(negedge i_sys_hclk);
      accepted = o_hready;
      @(posedge i_sys_hclk);
    end
  endtask

  task automatic fill_window();
    ahb_req_t req;
    for (int i = 0; i < N_INIT; i++)
    begin
      req       = '0;
      req.sel   = 1'b1;
      req.trans = (i == 0) ? NONSEQ : SEQ;
      req.write = 1'b1;
      req.size  = WORD;
      req.addr  = {16'h0000, win_base + 16'(4 * i)};
      issue(req, take_bits(32), 1'b0, 1'b0);
    end
  endtask

  task automatic random_transfers(input int count);
    ahb_req_t    req;
    logic [31:0] r;
    logic [31:0] a;
    logic [15:0] off;
    logic [15:0] last_off;
    hsize_e      last_size;
    logic        last_write;
    last_write = 1'b0;
    last_off   = '0;
    last_size  = WORD;
    for (int i = 0; i < count; i++)
    begin
      r         = take_bits(14);
      a         = take_bits(8);
      req       = '0;
      req.sel   = 1'b1;
      req.trans = r[3] ? SEQ : NONSEQ;
      req.write = r[4];
      req.size  = (r[6:5] == 2'd0) ? BYTE : ((r[6:5] == 2'd1) ? HALF : WORD);
      off       = {8'h00, a[7:0]};
      if (req.size == HALF)
        off[0] = 1'b0;
      else if (req.size == WORD)
        off[1:0] = 2'b00;
      if (r[2:0] == 3'd0)
      begin
        // idle, sometimes without select
        req.trans = IDLE;
        req.sel   = r[3];
      end
      else if (last_write && r[13])
      begin
        // read back what was just written
        req.write = 1'b0;
        req.size  = last_size;
        off       = last_off;
      end
      req.addr   = {16'h0000, win_base | off};
      last_write = (req.trans != IDLE) && req.write;
      last_off   = off;
      last_size  = req.size;
      issue(req, take_bits(32), r[9:7] == 3'd0, r[12:10] == 3'd0);
    end
  endtask

  task automatic drain();
    ahb_req_t idle_req;
    idle_req = '0;
    repeat (2) issue(idle_req, '0, 1'b0, 1'b0);
  endtask

  initial
  begin
    i_sys_hclk = 1'b0;
    forever #(CLK_PERIOD_NS / 2) i_sys_hclk = ~i_sys_hclk;
  end

  initial
  begin
    #(WATCHDOG_NS);
    $display("timeout: transfers did not complete within %0d ns", WATCHDOG_NS);
    $display("test failed");
    $finish;
  end

  initial
  begin : stimulus
    logic [31:0] seed_bits;
    lfsr_state     = 16'd57;
    prev_wdata     = '0;
    i_sys_rst_b    = 1'b0;
    i_ahb_req      = '0;
    i_hwdata       = '0;
    i_rd_deny      = 1'b0;
    i_wr_deny      = 1'b0;
    i_big_endian_b = 1'b1;
    // 256 byte window somewhere in the bank
    seed_bits      = take_bits(8);
    win_base       = {seed_bits[7:0], 8'h00};
    repeat (2) @(posedge i_sys_hclk);
    i_sys_rst_b <= 1'b1;
    @(posedge i_sys_hclk);
    fill_window();
    random_transfers(N_SEG);
    drain();
    i_big_endian_b <= 1'b0;
    random_transfers(N_SEG);
    drain();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  end

  // mid cycle check of one bus cycle against the model
  always @(negedge i_sys_hclk)
  begin : compare
    logic                         a_act;
    logic                         a_deny;
    logic                         busy;
    logic                         exp_ready;
    logic                         exp_idle;
    hresp_e                       exp_resp;
    logic [`SRAM_BANK_DATA_W-1:0] exp_data;
    if (!i_sys_rst_b)
    begin
      dp_valid = 1'b0;
      dp_raw   = 1'b0;
      dp_cyc   = 0;
    end
    else
    begin
      a_act  = i_ahb_req.sel && (i_ahb_req.trans == NONSEQ || i_ahb_req.trans == SEQ);
      a_deny = i_ahb_req.write ? i_wr_deny : i_rd_deny;
      // error and read-after-write both cost one low cycle
      exp_ready = 1'b1;
      if (dp_valid && (dp_deny || dp_raw))
        exp_ready = (dp_cyc != 0);
      exp_resp = (dp_valid && dp_deny) ? ERROR : OKAY;
      busy     = dp_valid && !dp_deny && (dp_write || (dp_raw && dp_cyc == 0));
      exp_idle = !(a_act && exp_ready && !a_deny) && !busy;
      checks += 3;
      assert (o_hready === exp_ready)
      else flag_error($sformatf("o_hready %b, expected %b", o_hready, exp_ready));
      assert (o_hresp === exp_resp)
      else flag_error($sformatf("o_hresp %0d, expected %0d", o_hresp, exp_resp));
      assert (o_idle === exp_idle)
      else flag_error($sformatf("o_idle %b, expected %b", o_idle, exp_idle));
      if (dp_valid && !dp_deny && exp_ready)
      begin
        if (dp_write)
        begin
          commit_write(dp_addr, dp_size, i_hwdata, i_big_endian_b);
        end
        else
        begin
          checks++;
          exp_data = expected_rdata(dp_addr, dp_size, i_big_endian_b);
          assert (o_hrdata === exp_data)
          else flag_error($sformatf("read 0x%04h: o_hrdata 0x%08h, expected 0x%08h",
                                    dp_addr, o_hrdata, exp_data));
        end
      end
      if (exp_ready)
      begin
        dp_raw   = a_act && !a_deny && !i_ahb_req.write && dp_valid && dp_write && !dp_deny;
        dp_valid = a_act;
        dp_write = i_ahb_req.write;
        dp_deny  = a_deny;
        dp_size  = i_ahb_req.size;
        dp_addr  = i_ahb_req.addr[15:0];
        dp_cyc   = 0;
      end
      else
      begin
        dp_cyc++;
      end
    end
  end

endmodule

`default_nettype wire

//--- source/sram_bank_top.sv
//==========================================================
// 64 KiB AHB-Lite SRAM bank
// region check, slave, lane steering and memory array
//==========================================================
`default_nettype none

`include "sram_bank_defs.svh"

module sram_bank_top
  import sram_bank_pkg::*;
(
  input  wire logic                         i_sys_hclk,
  input  wire logic                         i_sys_rst_b,
  input  wire ahb_req_t                     i_ahb_req,
  input  wire logic [`SRAM_BANK_DATA_W-1:0] i_hwdata,
  input  wire logic                         i_rd_deny,
  input  wire logic                         i_wr_deny,
  input  wire logic                         i_big_endian_b,
  output logic [`SRAM_BANK_DATA_W-1:0]      o_hrdata,
  output logic                              o_hready,
  output hresp_e                            o_hresp,
  output logic                              o_idle
);

  ahb_req_t                     masked_req;
  logic                         slv_hready;
  hresp_e                       slv_hresp;
  sram_req_t                    sram_req;
  hsize_e                       dphase_size;
  logic [1:0]                   dphase_addr;
  logic                         dphase_sel;
  logic [`SRAM_BANK_DATA_W-1:0] mem_wdata;
  logic [`SRAM_BANK_DATA_W-1:0] mem_rdata;

  region_deny_ctrl u_region_deny_ctrl (
    .i_sys_hclk   (i_sys_hclk),
    .i_sys_rst_b  (i_sys_rst_b),
    .i_ahb_req    (i_ahb_req),
    .i_rd_deny    (i_rd_deny),
    .i_wr_deny    (i_wr_deny),
    .o_ahb_req    (masked_req),
    .i_slv_hready (slv_hready),
    .i_slv_hresp  (slv_hresp),
    .o_hready     (o_hready),
    .o_hresp      (o_hresp)
  );

  ahb_sram_slave u_ahb_sram_slave (
    .i_sys_hclk    (i_sys_hclk),
    .i_sys_rst_b   (i_sys_rst_b),
    .i_ahb_req     (masked_req),
    .o_hready      (slv_hready),
    .o_hresp       (slv_hresp),
    .o_sram_req    (sram_req),
    .o_dphase_size (dphase_size),
    .o_dphase_addr (dphase_addr),
    .o_dphase_sel  (dphase_sel),
    .o_idle        (o_idle)
  );

  endian_lane_steer u_endian_lane_steer (
    .i_big_endian_b (i_big_endian_b),
    .i_dphase_sel   (dphase_sel),
    .i_dphase_size  (dphase_size),
    .i_dphase_addr  (dphase_addr),
    .i_hwdata       (i_hwdata),
    .o_mem_wdata    (mem_wdata),
    .i_mem_rdata    (mem_rdata),
    .o_hrdata       (o_hrdata)
  );

  sram_byte_array u_sram_byte_array (
    .i_sys_hclk  (i_sys_hclk),
    .i_sys_rst_b (i_sys_rst_b),
    .i_sram_req  (sram_req),
    .i_wdata     (mem_wdata),
    .o_rdata     (mem_rdata)
  );

endmodule

`default_nettype wire

//--- source/sram_byte_array.sv
//==========================================================
// 16K x 32 synchronous memory with byte write enables
// read data is registered and zero after an idle cycle
//==========================================================
`default_nettype none

`include "sram_bank_defs.svh"

module sram_byte_array
  import sram_bank_pkg::*;
(
  input  wire logic                         i_sys_hclk,
  input  wire logic                         i_sys_rst_b,
  input  wire sram_req_t                    i_sram_req,
  input  wire logic [`SRAM_BANK_DATA_W-1:0] i_wdata,
  output logic [`SRAM_BANK_DATA_W-1:0]      o_rdata
);

  localparam int LANE_W = `SRAM_BANK_DATA_W / `SRAM_BANK_LANES;
  localparam int DEPTH  = 2 ** `SRAM_BANK_WORD_ADDR_W;

  logic [`SRAM_BANK_DATA_W-1:0]      mem_q [DEPTH];
  logic [`SRAM_BANK_DATA_W-1:0]      rdata_q;
  logic [`SRAM_BANK_WORD_ADDR_W-1:0] word_idx;
  logic [`SRAM_BANK_LANES-1:0]       byte_en;
  logic                              sel_q;

  assign word_idx = i_sram_req.addr[`SRAM_BANK_WORD_ADDR_W+1:2];

  // lanes touched by size and low address
  always_comb
  begin
    byte_en = '0;
    case (i_sram_req.size)
      BYTE:
        byte_en[i_sram_req.addr[1:0]] = 1'b1;
      HALF:
        byte_en[{i_sram_req.addr[1], 1'b0} +: 2] = 2'b11;
      WORD:
        byte_en = '1;
      default:
        byte_en = '0;
    endcase
  end

  // read before write on a selected cycle
  always_ff @(posedge i_sys_hclk)
  begin
    if (i_sram_req.sel)
    begin
      if (i_sram_req.write)
      begin
        for (int i = 0; i < `SRAM_BANK_LANES; i++)
        begin
          if (byte_en[i])
          begin
            mem_q[word_idx][LANE_W*i +: LANE_W] <= i_wdata[LANE_W*i +: LANE_W];
          end
        end
      end
      rdata_q <= mem_q[word_idx];
    end
  end

  // output mux select, follows the access by one cycle
  always_ff @(posedge i_sys_hclk or negedge i_sys_rst_b)
  begin
    if (!i_sys_rst_b)
    begin
      sel_q <= 1'b0;
    end
    else
    begin
      sel_q <= i_sram_req.sel;
    end
  end

  assign o_rdata = sel_q ? rdata_q : '0;

endmodule

`default_nettype wire

//--- source/endian_lane_steer.sv
//==========================================================
// byte lane steering between the AHB bus and the memory
// big-endian mode swaps lanes for byte and halfword accesses
//==========================================================
`default_nettype none

`include "sram_bank_defs.svh"

module endian_lane_steer
  import sram_bank_pkg::*;
(
  input  wire logic                         i_big_endian_b,
  input  wire logic                         i_dphase_sel,
  input  wire hsize_e                       i_dphase_size,
  input  wire logic [1:0]                   i_dphase_addr,
  input  wire logic [`SRAM_BANK_DATA_W-1:0] i_hwdata,
  output logic [`SRAM_BANK_DATA_W-1:0]      o_mem_wdata,
  input  wire logic [`SRAM_BANK_DATA_W-1:0] i_mem_rdata,
  output logic [`SRAM_BANK_DATA_W-1:0]      o_hrdata
);

  localparam int LANE_W = `SRAM_BANK_DATA_W / `SRAM_BANK_LANES;
  localparam int HALF_W = 2 * LANE_W;

  logic be_swap;

  // places the selected source lanes at lane_idx, other lanes zero
  // byte: lane k takes source lane 3-k
  // half: upper half takes lower source half and the reverse
  function automatic logic [`SRAM_BANK_DATA_W-1:0] swap_lanes(
    input logic [`SRAM_BANK_DATA_W-1:0] data,
    input hsize_e                       size,
    input logic [1:0]                   lane_idx
  );
    logic [`SRAM_BANK_DATA_W-1:0] res;
    int                           dst;
    int                           src;
    res = '0;
    case (size)
      BYTE:
      begin
        dst = int'(lane_idx);
        src = `SRAM_BANK_LANES - 1 - dst;
        res[LANE_W*dst +: LANE_W] = data[LANE_W*src +: LANE_W];
      end
      HALF:
      begin
        dst = int'(lane_idx[1]);
        src = 1 - dst;
        res[HALF_W*dst +: HALF_W] = data[HALF_W*src +: HALF_W];
      end
      default:
        res = data;
    endcase
    return res;
  endfunction

  // only active inside a data phase
  assign be_swap = !i_big_endian_b && i_dphase_sel;

  // write data lands in the memory lane of its address
  assign o_mem_wdata = be_swap ? swap_lanes(i_hwdata, i_dphase_size, i_dphase_addr)
                               : i_hwdata;

  // read is the mirror image, so steer towards the mirrored lane
  assign o_hrdata = be_swap ? swap_lanes(i_mem_rdata, i_dphase_size, ~i_dphase_addr)
                            : i_mem_rdata;

endmodule

`default_nettype wire

//--- source/ahb_sram_slave.sv
//==========================================================
// AHB-Lite slave for the SRAM array
// buffers one write into its data phase and stalls a read
// that collides with it for one wait state
//==========================================================
`default_nettype none

`include "sram_bank_defs.svh"

module ahb_sram_slave
  import sram_bank_pkg::*;
(
  input  wire logic     i_sys_hclk,
  input  wire logic     i_sys_rst_b,
  input  wire ahb_req_t i_ahb_req,
  output logic          o_hready,
  output hresp_e        o_hresp,
  output sram_req_t     o_sram_req,
  output hsize_e        o_dphase_size,
  output logic [1:0]    o_dphase_addr,
  output logic          o_dphase_sel,
  output logic          o_idle
);

  logic                         a_act;
  logic                         rd_sel;
  logic                         raw_hit;
  logic                         raw_stall_q;
  logic                         buf_sel_q;
  logic                         buf_write_q;
  hsize_e                       buf_size_q;
  logic [`SRAM_BANK_ADDR_W-1:0] buf_addr_q;
  sram_req_t                    buf_req;
  sram_req_t                    rd_req;

  // qualified by our own ready, we are the only slave
  assign a_act = i_ahb_req.sel && o_hready &&
                 (i_ahb_req.trans == NONSEQ || i_ahb_req.trans == SEQ);

  // reads go to the memory in their address phase
  assign rd_sel = a_act && !i_ahb_req.write;

  // read collides with the write done this cycle
  assign raw_hit = buf_sel_q && buf_write_q && rd_sel;

  always_ff @(posedge i_sys_hclk or negedge i_sys_rst_b)
  begin
    if (!i_sys_rst_b)
    begin
      buf_sel_q   <= 1'b0;
      buf_write_q <= 1'b0;
      raw_stall_q <= 1'b0;
    end
    else
    begin
      // a write is parked for its data phase, a colliding read
      // is parked for the wait state
      buf_sel_q   <= (a_act && i_ahb_req.write) || raw_hit;
      buf_write_q <= a_act && i_ahb_req.write;
      raw_stall_q <= raw_hit;
    end
  end

  always_ff @(posedge i_sys_hclk)
  begin
    if (a_act)
    begin
      buf_size_q <= i_ahb_req.size;
      buf_addr_q <= i_ahb_req.addr;
    end
  end

  assign buf_req = '{sel: 1'b1, write: buf_write_q, size: buf_size_q, addr: buf_addr_q};
  assign rd_req  = '{sel: rd_sel, write: 1'b0, size: i_ahb_req.size, addr: i_ahb_req.addr};

  // buffered access has priority over the direct read
  assign o_sram_req = buf_sel_q ? buf_req : rd_req;

  // data phase info for lane steering, held while stalled
  always_ff @(posedge i_sys_hclk or negedge i_sys_rst_b)
  begin
    if (!i_sys_rst_b)
    begin
      o_dphase_sel  <= 1'b0;
      o_dphase_size <= BYTE;
      o_dphase_addr <= 2'b00;
    end
    else if (o_hready)
    begin
      o_dphase_sel  <= a_act;
      o_dphase_size <= i_ahb_req.size;
      o_dphase_addr <= i_ahb_req.addr[1:0];
    end
  end

  assign o_hready = !raw_stall_q;
  assign o_hresp  = OKAY;

  assign o_idle = !a_act && !buf_sel_q;

  // wider transfers are not handled by the lane logic
  property p_size_max_word;
    @(posedge i_sys_hclk) disable iff (!i_sys_rst_b)
      a_act |-> (i_ahb_req.size <= WORD);
  endproperty

  a_size_max_word: assert property (p_size_max_word);

endmodule

`default_nettype wire

//--- source/region_deny_ctrl.sv
//==========================================================
// region protection in front of the AHB slave
// denied transfers are hidden from the slave and answered
// with the two-cycle ERROR response
//==========================================================
`default_nettype none

module region_deny_ctrl
  import sram_bank_pkg::*;
(
  input  wire logic     i_sys_hclk,
  input  wire logic     i_sys_rst_b,
  input  wire ahb_req_t i_ahb_req,
  input  wire logic     i_rd_deny,
  input  wire logic     i_wr_deny,
  output ahb_req_t      o_ahb_req,
  input  wire logic     i_slv_hready,
  input  wire hresp_e   i_slv_hresp,
  output logic          o_hready,
  output hresp_e        o_hresp
);

  logic a_act;
  logic deny_now;
  // first ERROR cycle, hready low
  logic err_first_q;
  // second ERROR cycle, hready high
  logic err_second_q;
  logic err_wait;

  assign a_act = i_ahb_req.sel && o_hready &&
                 (i_ahb_req.trans == NONSEQ || i_ahb_req.trans == SEQ);

  // deny flag picked by direction
  assign deny_now = a_act && (i_ahb_req.write ? i_wr_deny : i_rd_deny);

  assign err_wait = err_first_q && !err_second_q;

  // the address phase held during the low cycle is not accepted yet
  // so the slave must not see it either
  always_comb
  begin
    o_ahb_req = i_ahb_req;
    if (deny_now || err_wait)
    begin
      o_ahb_req.sel   = 1'b0;
      o_ahb_req.trans = IDLE;
    end
  end

  always_ff @(posedge i_sys_hclk or negedge i_sys_rst_b)
  begin
    if (!i_sys_rst_b)
    begin
      err_first_q  <= 1'b0;
      err_second_q <= 1'b0;
    end
    else
    begin
      // a new denial in the second cycle restarts the sequence
      err_first_q  <= deny_now || err_wait;
      err_second_q <= err_wait;
    end
  end

  // error sequence overrides whatever the slave reports
  assign o_hready = err_first_q ? err_second_q : i_slv_hready;
  assign o_hresp  = err_first_q ? ERROR : i_slv_hresp;

  // low ERROR cycle is followed by one high ERROR cycle
  // and no slave wait state is hidden underneath it
  property p_err_two_cycles;
    @(posedge i_sys_hclk) disable iff (!i_sys_rst_b)
      (o_hresp == ERROR && !o_hready) |->
        i_slv_hready ##1 (o_hresp == ERROR && o_hready && i_slv_hready);
  endproperty

  a_err_two_cycles: assert property (p_err_two_cycles);

endmodule

`default_nettype wire

//--- source/sram_bank_pkg.sv
//==========================================================
// AHB encodings and request structs for the SRAM bank
// imported by every block that moves a request or response
//==========================================================
`default_nettype none

`include "sram_bank_defs.svh"

package sram_bank_pkg;

  // HTRANS encoding
  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    BUSY   = 2'b01,
    NONSEQ = 2'b10,
    SEQ    = 2'b11
  } htrans_e;

  // HSIZE, nothing above a word is supported
  typedef enum logic [2:0] {
    BYTE = 3'b000,
    HALF = 3'b001,
    WORD = 3'b010
  } hsize_e;

  // HRESP, RETRY is never issued by this bank
  typedef enum logic [1:0] {
    OKAY  = 2'b00,
    ERROR = 2'b01,
    RETRY = 2'b10
  } hresp_e;

  // one AHB address phase
  typedef struct packed {
    logic                         sel;
    htrans_e                      trans;
    logic                         write;
    hsize_e                       size;
    logic [`SRAM_BANK_ADDR_W-1:0] addr;
  } ahb_req_t;

  // one memory access as seen by the array
  typedef struct packed {
    logic                         sel;
    logic                         write;
    hsize_e                       size;
    logic [`SRAM_BANK_ADDR_W-1:0] addr;
  } sram_req_t;

endpackage

`default_nettype wire

//--- source/sram_bank_defs.svh
//==========================================================
// width macros shared by the 64 KiB AHB-Lite SRAM bank
// included by the package and by every block sizing data
//==========================================================
`ifndef SRAM_BANK_DEFS_SVH
`define SRAM_BANK_DEFS_SVH

// AHB data bus, same width as one memory word
`define SRAM_BANK_DATA_W 32

// full AHB address carried through the bank
`define SRAM_BANK_ADDR_W 32

// word index inside the bank
// 14 bits give 16384 words of 4 bytes, so 64 KiB
`define SRAM_BANK_WORD_ADDR_W 14

// byte lanes per word
`define SRAM_BANK_LANES 4

`endif
